/* common/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_SETS 8
`define CACHE_WAYS 2
`define BLOCK_WORDS 2

// word memory behind the controller
`define RAM_LAT 3
`define RAM_DEPTH 1024

`endif

/* common/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

  // address split widths
  parameter int IDX_W = $clog2(`CACHE_SETS);
  parameter int BLK_W = $clog2(`BLOCK_WORDS);
  parameter int TAG_W = 32 - IDX_W - BLK_W - 2;
  parameter int WAY_W = $clog2(`CACHE_WAYS);
  parameter int RAM_AW = $clog2(`RAM_DEPTH);

  typedef logic [31:0] word_t;

  // byte address as seen by the cache
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [BLK_W-1:0] blkoff;
    logic [1:0]       bytoff;
  } daddr_t;

  // one way of one set
  typedef struct packed {
    logic                         valid;
    logic                         dirty;
    logic [TAG_W-1:0]             tag;
    word_t [`BLOCK_WORDS-1:0]     data;
  } dcache_frame_t;

  typedef enum logic [3:0] {
    idle,
    wb1,
    wb2,
    fill1,
    fill2,
    flush_scan,
    flush_wb1,
    flush_wb2,
    flushed_st
  } dcache_state_t;

endpackage

/* dcache/dcache.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module dcache (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             dmemren,
  input  logic             dmemwen,
  input  logic             halt,
  input  cache_pkg::word_t dmemaddr,
  input  cache_pkg::word_t dmemstore,
  output logic             dhit,
  output logic             flushed,
  output cache_pkg::word_t dmemload,
  output logic             mem_ren,
  output logic             mem_wen,
  output cache_pkg::word_t mem_addr,
  output cache_pkg::word_t mem_store,
  input  cache_pkg::word_t mem_load,
  input  logic             mem_wait
);

  localparam int IDX_W = cache_pkg::IDX_W;
  localparam int WAY_W = cache_pkg::WAY_W;
  localparam int CNT_W = IDX_W + WAY_W;

  cache_pkg::dcache_frame_t frames [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] lru;
  cache_pkg::dcache_state_t state, next_state;
  logic [WAY_W-1:0] victim;
  logic [CNT_W-1:0] flush_cnt;

  cache_pkg::daddr_t addr;
  logic [`CACHE_WAYS-1:0] way_hit;
  logic [WAY_W-1:0] hit_way;
  logic req;
  logic hit;
  logic [IDX_W-1:0] flush_set;
  logic [WAY_W-1:0] flush_way;
  logic [IDX_W-1:0] wb_set;
  logic [WAY_W-1:0] wb_way;
  cache_pkg::dcache_frame_t wb_frame;
  logic miss_dirty;
  logic flush_dirty;
  logic mem_done;

  assign addr = dmemaddr;
  assign req = dmemren | dmemwen;
  assign flush_set = flush_cnt[CNT_W-1:WAY_W];
  assign flush_way = flush_cnt[WAY_W-1:0];

  // tag compare on both ways
  always_comb begin
    way_hit = '0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      way_hit[w] = frames[w][addr.idx].valid && (frames[w][addr.idx].tag == addr.tag);
      if (way_hit[w])
        hit_way = WAY_W'(w);
    end
  end

  assign hit = |way_hit;
  assign dhit = (state == cache_pkg::idle) && !halt && req && hit;
  assign dmemload = frames[hit_way][addr.idx].data[addr.blkoff];
  assign flushed = (state == cache_pkg::flushed_st) && halt;

  assign miss_dirty = frames[lru[addr.idx]][addr.idx].valid &&
                      frames[lru[addr.idx]][addr.idx].dirty;
  assign flush_dirty = frames[flush_way][flush_set].valid &&
                       frames[flush_way][flush_set].dirty;

  // victim of the current index, or the block the flush walk points at
  always_comb begin
    if (state == cache_pkg::flush_wb1 || state == cache_pkg::flush_wb2) begin
      wb_set = flush_set;
      wb_way = flush_way;
    end else begin
      wb_set = addr.idx;
      wb_way = victim;
    end
  end

  assign wb_frame = frames[wb_way][wb_set];

  always_comb begin
    mem_ren = 1'b0;
    mem_wen = 1'b0;
    mem_addr = '0;
    mem_store = '0;
    case (state)
      cache_pkg::wb1, cache_pkg::flush_wb1: begin
        mem_wen = 1'b1;
        mem_addr = {wb_frame.tag, wb_set, 1'b0, 2'b00};
        mem_store = wb_frame.data[0];
      end
      cache_pkg::wb2, cache_pkg::flush_wb2: begin
        mem_wen = 1'b1;
        mem_addr = {wb_frame.tag, wb_set, 1'b1, 2'b00};
        mem_store = wb_frame.data[1];
      end
      cache_pkg::fill1: begin
        mem_ren = 1'b1;
        mem_addr = {addr.tag, addr.idx, 1'b0, 2'b00};
      end
      cache_pkg::fill2: begin
        mem_ren = 1'b1;
        mem_addr = {addr.tag, addr.idx, 1'b1, 2'b00};
      end
      default: ;
    endcase
  end

  assign mem_done = (mem_ren | mem_wen) && !mem_wait;

  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::idle: begin
        if (halt)
          next_state = cache_pkg::flush_scan;
        else if (req && !hit)
          next_state = miss_dirty ? cache_pkg::wb1 : cache_pkg::fill1;
      end
      cache_pkg::wb1: if (mem_done) next_state = cache_pkg::wb2;
      cache_pkg::wb2: if (mem_done) next_state = cache_pkg::fill1;
      cache_pkg::fill1: if (mem_done) next_state = cache_pkg::fill2;
      // back to idle, where the access retries as a hit
      cache_pkg::fill2: if (mem_done) next_state = cache_pkg::idle;
      cache_pkg::flush_scan: begin
        if (flush_dirty)
          next_state = cache_pkg::flush_wb1;
        else if (&flush_cnt)
          next_state = cache_pkg::flushed_st;
      end
      cache_pkg::flush_wb1: if (mem_done) next_state = cache_pkg::flush_wb2;
      cache_pkg::flush_wb2: if (mem_done) next_state = cache_pkg::flush_scan;
      cache_pkg::flushed_st: if (!halt) next_state = cache_pkg::idle;
      default: next_state = cache_pkg::idle;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= cache_pkg::idle;
      frames <= '{default: '0};
      lru <= '0;
      victim <= '0;
      flush_cnt <= '0;
    end else begin
      state <= next_state;
      case (state)
        cache_pkg::idle: begin
          flush_cnt <= '0;
          if (dhit) begin
            // lru bit names the way to evict next
            lru[addr.idx] <= ~hit_way;
            if (dmemwen) begin
              frames[hit_way][addr.idx].data[addr.blkoff] <= dmemstore;
              frames[hit_way][addr.idx].dirty <= 1'b1;
            end
          end else if (!halt && req) begin
            victim <= lru[addr.idx];
          end
        end
        cache_pkg::wb2: begin
          if (mem_done)
            frames[victim][addr.idx].dirty <= 1'b0;
        end
        cache_pkg::fill1: begin
          if (mem_done) begin
            frames[victim][addr.idx].valid <= 1'b0;
            frames[victim][addr.idx].data[0] <= mem_load;
          end
        end
        cache_pkg::fill2: begin
          if (mem_done) begin
            frames[victim][addr.idx].valid <= 1'b1;
            frames[victim][addr.idx].dirty <= 1'b0;
            frames[victim][addr.idx].tag <= addr.tag;
            frames[victim][addr.idx].data[1] <= mem_load;
          end
        end
        cache_pkg::flush_scan: begin
          if (!flush_dirty) begin
            if (&flush_cnt) begin
              // drop every block once the walk is done
              frames <= '{default: '0};
              lru <= '0;
            end else begin
              flush_cnt <= flush_cnt + 1'b1;
            end
          end
        end
        cache_pkg::flush_wb2: begin
          if (mem_done)
            frames[flush_way][flush_set].dirty <= 1'b0;
        end
        default: ;
      endcase
    end
  end

endmodule

/* design/memory_control.sv */
`timescale 1ns/1ps

module memory_control (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          mem_ren,
  input  logic                          mem_wen,
  input  cache_pkg::word_t              mem_addr,
  input  cache_pkg::word_t              mem_store,
  output cache_pkg::word_t              mem_load,
  output logic                          mem_wait,
  output logic                          ram_req,
  output logic                          ram_we,
  output logic [cache_pkg::RAM_AW-1:0]  ram_addr,
  output cache_pkg::word_t              ram_wdata,
  input  cache_pkg::word_t              ram_rdata,
  input  logic                          ram_done
);

  typedef enum logic {
    mc_idle,
    mc_busy
  } mc_state_t;

  mc_state_t state;
  logic req;
  logic done;
  cache_pkg::word_t load_q;

  assign req = mem_ren | mem_wen;

  // done marks the cycle the cache sees completion, so no restart then
  assign ram_req = (state == mc_busy) || (req && !done);
  assign ram_we = mem_wen;
  assign ram_addr = mem_addr[cache_pkg::RAM_AW+1:2];
  assign ram_wdata = mem_store;

  assign mem_wait = req && !done;
  assign mem_load = load_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= mc_idle;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        mc_idle: begin
          if (req && !done)
            state <= mc_busy;
        end
        mc_busy: begin
          if (ram_done) begin
            state <= mc_idle;
            done <= 1'b1;
          end
        end
        default: state <= mc_idle;
      endcase
    end
  end

  // read data held for the completion cycle
  always_ff @(posedge CLK) begin
    if (state == mc_busy && ram_done)
      load_q <= ram_rdata;
  end

endmodule

/* design/ram.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module ram (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          ram_req,
  input  logic                          ram_we,
  input  logic [cache_pkg::RAM_AW-1:0]  ram_addr,
  input  cache_pkg::word_t              ram_wdata,
  output cache_pkg::word_t              ram_rdata,
  output logic                          ram_done
);

  localparam int CNT_W = $clog2(`RAM_LAT + 1);

  cache_pkg::word_t mem [`RAM_DEPTH];
  logic [CNT_W-1:0] cnt;
  logic access;

  // the access happens at the edge that ends the last wait cycle
  assign access = ram_req && !ram_done && (cnt == CNT_W'(`RAM_LAT - 1));

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
      ram_done <= 1'b0;
    end else begin
      ram_done <= access;
      if (!ram_req || ram_done || access)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

  // address-derived start pattern
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < `RAM_DEPTH; w++)
        mem[w] <= (cache_pkg::word_t'(w) * 32'h0101_0101) ^ 32'hA5A5_0000;
    end else if (access && ram_we) begin
      mem[ram_addr] <= ram_wdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (access)
      ram_rdata <= ram_we ? ram_wdata : mem[ram_addr];
  end

endmodule

/* design/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             dmemren,
  input  logic             dmemwen,
  input  logic             halt,
  input  cache_pkg::word_t dmemaddr,
  input  cache_pkg::word_t dmemstore,
  output logic             dhit,
  output logic             flushed,
  output cache_pkg::word_t dmemload
);

  // cache to controller
  logic mem_ren;
  logic mem_wen;
  logic mem_wait;
  cache_pkg::word_t mem_addr;
  cache_pkg::word_t mem_store;
  cache_pkg::word_t mem_load;

  // controller to ram
  logic ram_req;
  logic ram_we;
  logic ram_done;
  logic [cache_pkg::RAM_AW-1:0] ram_addr;
  cache_pkg::word_t ram_wdata;
  cache_pkg::word_t ram_rdata;

  dcache i_dcache (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemren   (dmemren),
    .dmemwen   (dmemwen),
    .halt      (halt),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dhit      (dhit),
    .flushed   (flushed),
    .dmemload  (dmemload),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_store (mem_store),
    .mem_load  (mem_load),
    .mem_wait  (mem_wait)
  );

  memory_control i_memory_control (
    .CLK       (CLK),
    .nRST      (nRST),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_store (mem_store),
    .mem_load  (mem_load),
    .mem_wait  (mem_wait),
    .ram_req   (ram_req),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .ram_done  (ram_done)
  );

  ram i_ram (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_req   (ram_req),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .ram_done  (ram_done)
  );

endmodule

/* tb/cache_tb_ref.svh */
`ifndef CACHE_TB_REF_SVH
`define CACHE_TB_REF_SVH

// shadow of the word memory behind the cache
cache_pkg::word_t shadow [`RAM_DEPTH];
logic written [`RAM_DEPTH];

// word w starts as w * 0x01010101 xor 0xa5a50000
function automatic cache_pkg::word_t initial_word(int w);
  return (cache_pkg::word_t'(w) * 32'h0101_0101) ^ 32'hA5A5_0000;
endfunction

function automatic int word_index(cache_pkg::word_t addr);
  return int'(addr[cache_pkg::RAM_AW+1:2]);
endfunction

task automatic init_shadow();
  for (int w = 0; w < `RAM_DEPTH; w++) begin
    shadow[w] = initial_word(w);
    written[w] = 1'b0;
  end
endtask

// what a load of this address must return
function automatic cache_pkg::word_t expected_load(cache_pkg::word_t addr);
  return shadow[word_index(addr)];
endfunction

task automatic record_store(cache_pkg::word_t addr, cache_pkg::word_t data);
  shadow[word_index(addr)] = data;
  written[word_index(addr)] = 1'b1;
endtask

task automatic check_value(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
  if (got !== exp) begin
    $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

`endif

/* tb/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb;

  localparam int HIT_TIMEOUT = 8 * (`RAM_LAT + 3) + 20;
  localparam int FLUSH_TIMEOUT = 4 * `CACHE_SETS * `CACHE_WAYS * (`RAM_LAT + 3) + 64;
  localparam int RAND_OPS = 300;
  localparam int RAND_BASE = 256;
  localparam int TAG_W = cache_pkg::TAG_W;
  localparam int IDX_W = cache_pkg::IDX_W;
  localparam int BLK_W = cache_pkg::BLK_W;

  logic CLK;
  logic nRST;
  logic dmemren;
  logic dmemwen;
  logic halt;
  cache_pkg::word_t dmemaddr;
  cache_pkg::word_t dmemstore;
  logic dhit;
  logic flushed;
  cache_pkg::word_t dmemload;

  int loads_issued;
  int loads_checked;
  logic first_cycle_hit;

  cache_subsystem i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemren   (dmemren),
    .dmemwen   (dmemwen),
    .halt      (halt),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dhit      (dhit),
    .flushed   (flushed),
    .dmemload  (dmemload)
  );

  always #10 CLK = ~CLK;

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  `include "cache_tb_ref.svh"

  // sampled mid-cycle away from the edges
  always @(negedge CLK) begin
    if (nRST && dhit) begin
      if (dmemren) begin
        check_value("dmemload", dmemload, expected_load(dmemaddr));
        loads_checked++;
      end else if (dmemwen) begin
        record_store(dmemaddr, dmemstore);
      end
    end
  end

  function automatic cache_pkg::word_t make_addr(int tag, int idx, int blk);
    cache_pkg::daddr_t a;
    a.tag = TAG_W'(tag);
    a.idx = IDX_W'(idx);
    a.blkoff = BLK_W'(blk);
    a.bytoff = 2'b00;
    return a;
  endfunction

  task automatic wait_for_hit();
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (!dhit && cycles > HIT_TIMEOUT) begin
        $display("timeout: no dhit for the access to address 0x%08h", dmemaddr);
        abort_run();
      end
    end while (!dhit);
    first_cycle_hit = (cycles == 1);
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_for_flush();
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (!flushed && cycles > FLUSH_TIMEOUT) begin
        $display("timeout: the cache never reported flushed after halt");
        abort_run();
      end
    end while (!flushed);
  endtask

  task automatic run_access(logic wr, cache_pkg::word_t addr, cache_pkg::word_t data);
    dmemren = !wr;
    dmemwen = wr;
    dmemaddr = addr;
    dmemstore = data;
    if (!wr)
      loads_issued++;
    wait_for_hit();
    dmemren = 1'b0;
    dmemwen = 1'b0;
  endtask

  task automatic load_word(cache_pkg::word_t addr);
    run_access(1'b0, addr, '0);
  endtask

  task automatic store_word(cache_pkg::word_t addr, cache_pkg::word_t data);
    run_access(1'b1, addr, data);
  endtask

  initial begin
    cache_pkg::word_t a;
    cache_pkg::word_t b;
    cache_pkg::word_t c;
    int w;
    int last_blk;
    CLK = 1'b0;
    nRST = 1'b0;
    dmemren = 1'b0;
    dmemwen = 1'b0;
    halt = 1'b0;
    dmemaddr = '0;
    dmemstore = '0;
    loads_issued = 0;
    loads_checked = 0;
    first_cycle_hit = 1'b0;
    void'($urandom(16987));
    init_shadow();
    repeat (4) @(posedge CLK);
    #2;
    nRST = 1'b1;
    @(posedge CLK);
    #2;

    // cold reads
    load_word(32'h0000_0000);
    load_word(32'h0000_0004);
    load_word(32'h0000_0028);
    load_word(32'h0000_0ffc);

    // hits
    load_word(32'h0000_0028);
    store_word(32'h0000_0028, 32'hDEAD_BEEF);
    load_word(32'h0000_0028);
    store_word(32'h0000_002c, 32'h1234_5678);
    load_word(32'h0000_002c);
    load_word(32'h0000_0028);

    // three tags competing for set 0
    a = make_addr(4, 0, 0);
    b = make_addr(5, 0, 0);
    c = make_addr(6, 0, 1);
    store_word(a, 32'h1111_0001);
    store_word(b, 32'h2222_0001);
    store_word(c, 32'h3333_0001);
    load_word(a);
    store_word(b, 32'h2222_0002);
    load_word(c);
    load_word(b);
    store_word(a, 32'h1111_0002);
    load_word(a);
    load_word(c);
    load_word(b);

    for (int i = 0; i < RAND_OPS; i++) begin
      w = RAND_BASE + int'($urandom_range(63));
      if ($urandom_range(1) == 1)
        store_word(cache_pkg::word_t'(w) << 2, $urandom());
      else
        load_word(cache_pkg::word_t'(w) << 2);
    end

    // every stored word must come back from the RAM after the flush
    halt = 1'b1;
    wait_for_flush();
    @(posedge CLK);
    #2;
    halt = 1'b0;
    last_blk = -1;
    for (int k = 0; k < `RAM_DEPTH; k++) begin
      if (written[k]) begin
        load_word(cache_pkg::word_t'(k) << 2);
        // first load of each block must miss in the flushed cache
        if (k / `BLOCK_WORDS != last_blk)
          check_value("dhit", first_cycle_hit, 1'b0);
        last_blk = k / `BLOCK_WORDS;
      end
    end

    check_value("loads_checked", loads_checked, loads_issued);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* cache_subsystem.f */
+incdir+common
+incdir+tb
common/cache_pkg.sv
dcache/dcache.sv
design/memory_control.sv
design/ram.sv
design/cache_subsystem.sv
tb/cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsystem

export_include_dirs:
  - common

sources:
  - common/cache_pkg.sv
  - dcache/dcache.sv
  - design/memory_control.sv
  - design/ram.sv
  - design/cache_subsystem.sv

  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/cache_tb.sv
